// File: design/point_pkg.sv
package point_pkg;

    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } coord_t;

    typedef struct packed {
        logic p1;
        logic p2;
    } hit_t;

    typedef enum logic [0:0] {
        ROUND_PLACED = 1'b0,
        ROUND_SEEK   = 1'b1
    } round_state_t;

    typedef logic [4:0] score_t;

    typedef struct packed {
        logic [9:0] x_min;
        logic [9:0] x_max;
        logic [9:0] y_min;
        logic [9:0] y_max;
    } wall_t;

    localparam int GRID_PITCH  = 32;
    localparam int GRID_Y_MAX  = 736; // Lowest row fully inside the 768 line field
    localparam int POINT_SIZE  = 8;
    localparam int PLAYER_SIZE = 16;

    localparam coord_t START_POINT = '{x: 10'd512, y: 10'd64};
    localparam coord_t P1_START    = '{x: 10'd32, y: 10'd32};
    localparam coord_t P2_START    = '{x: 10'd992, y: 10'd736};

    localparam int WALL_COUNT = 4;
    localparam wall_t [0:WALL_COUNT-1] WALLS = '{
        '{x_min: 10'd192, x_max: 10'd232, y_min: 10'd160, y_max: 10'd400},
        '{x_min: 10'd416, x_max: 10'd640, y_min: 10'd300, y_max: 10'd316},
        '{x_min: 10'd720, x_max: 10'd760, y_min: 10'd448, y_max: 10'd700},
        '{x_min: 10'd96,  x_max: 10'd360, y_min: 10'd580, y_max: 10'd596}
    };

endpackage

// File: design/terrain_map.sv
`timescale 1ns/100ps

module terrain_map #(
    parameter int MARGIN = point_pkg::POINT_SIZE
) (
    input  point_pkg::coord_t cand,
    output logic              blocked
);

    localparam logic [10:0] M = 11'(MARGIN);

    logic [10:0] cx;
    logic [10:0] cy;
    logic        wall_hit;
    logic        on_start;

    assign cx = {1'b0, cand.x};
    assign cy = {1'b0, cand.y};

    // Square of half-width MARGIN against each wall, kept in 11 bits to avoid underflow
    always_comb begin
        wall_hit = 1'b0;
        for (int i = 0; i < point_pkg::WALL_COUNT; i++) begin
            if ((cx + M >= {1'b0, point_pkg::WALLS[i].x_min}) &&
                (cx <= {1'b0, point_pkg::WALLS[i].x_max} + M) &&
                (cy + M >= {1'b0, point_pkg::WALLS[i].y_min}) &&
                (cy <= {1'b0, point_pkg::WALLS[i].y_max} + M)) begin
                wall_hit = 1'b1;
            end
        end
    end

    assign on_start = (cand == point_pkg::P1_START) || (cand == point_pkg::P2_START);

    assign blocked = wall_hit || on_start;

endmodule

// File: design/cooldown_timer.sv
`timescale 1ns/100ps

module cooldown_timer #(
    parameter int COOLDOWN_CYCLES = 10000
) (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    output logic armed
);

    localparam int CW = $clog2(COOLDOWN_CYCLES + 1);
    localparam logic [CW-1:0] LIMIT = CW'(COOLDOWN_CYCLES);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            count <= '0;
        end else if (count != LIMIT) begin
            count <= count + 1'b1; // Saturates at LIMIT
        end
    end

    assign armed = (count == LIMIT);

endmodule

// File: design/score_keeper.sv
`timescale 1ns/100ps

module score_keeper (
    input  logic              clk,
    input  logic              rst,
    input  point_pkg::coord_t point,
    input  point_pkg::coord_t player1,
    input  point_pkg::coord_t player2,
    input  point_pkg::hit_t   award,
    output point_pkg::hit_t   hits,
    output point_pkg::score_t score1,
    output point_pkg::score_t score2
);

    localparam logic [9:0] REACH = 10'(point_pkg::POINT_SIZE + point_pkg::PLAYER_SIZE);

    function automatic logic [9:0] abs_diff(input logic [9:0] a, input logic [9:0] b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    function automatic logic overlaps(input point_pkg::coord_t pt, input point_pkg::coord_t pl);
        logic [9:0] dx;
        logic [9:0] dy;
        dx = abs_diff(pt.x, pl.x);
        dy = abs_diff(pt.y, pl.y);
        return (dx <= REACH) && (dy <= REACH);
    endfunction

    assign hits.p1 = overlaps(point, player1);
    assign hits.p2 = overlaps(point, player2);

    // 5-bit scores wrap from 31 back to 0
    always_ff @(posedge clk) begin
        if (rst) begin
            score1 <= '0;
            score2 <= '0;
        end else begin
            if (award.p1) begin
                score1 <= score1 + 1'b1;
            end
            if (award.p2) begin
                score2 <= score2 + 1'b1;
            end
        end
    end

endmodule

// File: design/point_round_fsm.sv
`timescale 1ns/100ps

module point_round_fsm (
    input  logic            clk,
    input  logic            rst,
    input  point_pkg::hit_t hits,
    input  logic            armed,
    input  logic            placed,
    output point_pkg::hit_t award,
    output logic            seek
);

    point_pkg::round_state_t state;
    point_pkg::round_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= point_pkg::ROUND_PLACED;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        award     = '0;
        seek      = 1'b0;
        case (state)
            point_pkg::ROUND_PLACED: begin
                if (armed) begin
                    award = hits; // Both players may score from one pickup
                    if (hits.p1 || hits.p2) begin
                        state_nxt = point_pkg::ROUND_SEEK;
                    end
                end
            end
            point_pkg::ROUND_SEEK: begin
                seek = 1'b1;
                if (placed) begin
                    state_nxt = point_pkg::ROUND_PLACED;
                end
            end
            default: begin
                state_nxt = point_pkg::ROUND_PLACED;
            end
        endcase
    end

endmodule

// File: design/point_spawner.sv
`timescale 1ns/100ps

module point_spawner #(
    parameter logic [4:0] LFSR_X_SEED = 5'h1F,
    parameter logic [4:0] LFSR_Y_SEED = 5'h1A
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              seek,
    output point_pkg::coord_t point,
    output logic              point_valid,
    output logic              placed
);

    localparam logic [9:0] PITCH = 10'(point_pkg::GRID_PITCH);
    localparam logic [9:0] Y_MAX = 10'(point_pkg::GRID_Y_MAX);

    logic [4:0]        lfsr_x;
    logic [4:0]        lfsr_y;
    logic              y_wrap;
    point_pkg::coord_t cand;
    logic              cand_blocked;
    logic              accept;

    // x^5 + x^3 + 1, period 31
    function automatic logic [4:0] lfsr_step(input logic [4:0] q);
        return {q[3:0], q[4] ^ q[2]};
    endfunction

    // x skips one step each y period so the pair walks all 961 combinations
    assign y_wrap = (lfsr_y == LFSR_Y_SEED);

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_x <= LFSR_X_SEED;
            lfsr_y <= LFSR_Y_SEED;
        end else begin
            lfsr_y <= lfsr_step(lfsr_y);
            if (!y_wrap) begin
                lfsr_x <= lfsr_step(lfsr_x);
            end
        end
    end

    assign cand.x = 10'(lfsr_x) * PITCH; // 32 to 992
    assign cand.y = 10'(lfsr_y) * PITCH; // Rows past Y_MAX are rejected below

    terrain_map #(
        .MARGIN(point_pkg::POINT_SIZE)
    ) u_terrain_map (
        .cand    (cand),
        .blocked (cand_blocked)
    );

    assign accept = (cand.y <= Y_MAX) && !cand_blocked && (cand != point);
    assign placed = seek && accept; // Same edge loads point and ends the search

    always_ff @(posedge clk) begin
        if (rst) begin
            point <= point_pkg::START_POINT;
        end else if (placed) begin
            point <= cand;
        end
    end

    // Low for the whole search, from the award edge to the placing edge
    assign point_valid = !seek;

endmodule

// File: design/point_game_top.sv
`timescale 1ns/100ps

module point_game_top #(
    parameter int         COOLDOWN_CYCLES = 10000,
    parameter logic [4:0] LFSR_X_SEED     = 5'h1F,
    parameter logic [4:0] LFSR_Y_SEED     = 5'h1A
) (
    input  logic              clk,
    input  logic              rst,
    input  point_pkg::coord_t player1,
    input  point_pkg::coord_t player2,
    output point_pkg::coord_t point,
    output logic              point_valid,
    output point_pkg::score_t score1,
    output point_pkg::score_t score2
);

    point_pkg::hit_t hits;
    point_pkg::hit_t award;
    logic            seek;
    logic            placed;
    logic            armed;

    point_round_fsm u_point_round_fsm (
        .clk    (clk),
        .rst    (rst),
        .hits   (hits),
        .armed  (armed),
        .placed (placed),
        .award  (award),
        .seek   (seek)
    );

    cooldown_timer #(
        .COOLDOWN_CYCLES(COOLDOWN_CYCLES)
    ) u_cooldown_timer (
        .clk     (clk),
        .rst     (rst),
        .restart (placed), // Cooldown runs again from each new point
        .armed   (armed)
    );

    point_spawner #(
        .LFSR_X_SEED(LFSR_X_SEED),
        .LFSR_Y_SEED(LFSR_Y_SEED)
    ) u_point_spawner (
        .clk         (clk),
        .rst         (rst),
        .seek        (seek),
        .point       (point),
        .point_valid (point_valid),
        .placed      (placed)
    );

    score_keeper u_score_keeper (
        .clk     (clk),
        .rst     (rst),
        .point   (point),
        .player1 (player1),
        .player2 (player2),
        .award   (award),
        .hits    (hits),
        .score1  (score1),
        .score2  (score2)
    );

endmodule

// File: sim/point_game_tb.sv
`timescale 1ns/100ps

module point_game_tb;

    localparam int COOLDOWN     = 200;
    localparam int PICKUP_LIMIT = COOLDOWN + 50;
    localparam int SPAWN_LIMIT  = 200;
    localparam int REACH        = point_pkg::POINT_SIZE + point_pkg::PLAYER_SIZE;

    logic              clk;
    logic              rst;
    point_pkg::coord_t player1;
    point_pkg::coord_t player2;
    point_pkg::coord_t point;
    logic              point_valid;
    point_pkg::score_t score1;
    point_pkg::score_t score2;

    point_pkg::score_t exp1; // Scores predicted from the pickups made so far
    point_pkg::score_t exp2;
    int                errors;

    point_game_top #(
        .COOLDOWN_CYCLES(COOLDOWN)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .player1     (player1),
        .player2     (player2),
        .point       (point),
        .point_valid (point_valid),
        .score1      (score1),
        .score2      (score2)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_coord(input string name, input point_pkg::coord_t got,
                               input point_pkg::coord_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got x=0x%h y=0x%h expected x=0x%h y=0x%h",
                     name, got.x, got.y, exp.x, exp.y);
        end
    endtask

    task automatic check_score(input string name, input point_pkg::score_t got,
                               input point_pkg::score_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    function automatic int abs_int(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // Player square touches point square when both axis gaps are within REACH
    function automatic bit in_reach(input point_pkg::coord_t pt, input point_pkg::coord_t pl);
        return (abs_int(int'(pt.x) - int'(pl.x)) <= REACH) &&
               (abs_int(int'(pt.y) - int'(pl.y)) <= REACH);
    endfunction

    function automatic bit hits_wall(input point_pkg::coord_t c);
        int m;
        bit hit;
        m = point_pkg::POINT_SIZE;
        hit = 1'b0;
        for (int i = 0; i < point_pkg::WALL_COUNT; i++) begin
            if ((int'(c.x) + m >= int'(point_pkg::WALLS[i].x_min)) &&
                (int'(c.x) - m <= int'(point_pkg::WALLS[i].x_max)) &&
                (int'(c.y) + m >= int'(point_pkg::WALLS[i].y_min)) &&
                (int'(c.y) - m <= int'(point_pkg::WALLS[i].y_max))) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_spawn(input point_pkg::coord_t prev, input point_pkg::coord_t cur);
        if ((cur.x % point_pkg::GRID_PITCH != 0) || (cur.y % point_pkg::GRID_PITCH != 0))
            flag_error($sformatf("new point (%0d,%0d) is off the grid", cur.x, cur.y));
        if ((cur.x < 32) || (cur.x > 992) || (cur.y < 32) || (cur.y > 736))
            flag_error($sformatf("new point (%0d,%0d) is outside the field", cur.x, cur.y));
        if (cur == prev)
            flag_error("new point is the same as the previous one");
        if ((cur == point_pkg::P1_START) || (cur == point_pkg::P2_START))
            flag_error($sformatf("new point (%0d,%0d) sits on a start cell", cur.x, cur.y));
        if (hits_wall(cur))
            flag_error($sformatf("new point (%0d,%0d) overlaps a wall", cur.x, cur.y));
    endtask

    task automatic wait_valid(input logic level, input int limit, input string what,
                              output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while ((n < limit) && !ok) begin
            @(negedge clk);
            if (point_valid === level)
                ok = 1'b1;
            n++;
        end
        if (!ok)
            flag_error($sformatf("timed out after %0d cycles waiting for %s", limit, what));
    endtask

    // Puts the chosen players at the edge of reach and follows the pickup through the respawn
    task automatic do_pickup(input bit use1, input bit use2);
        point_pkg::coord_t prev;
        point_pkg::coord_t pos1;
        point_pkg::coord_t pos2;
        bit ok;
        prev = point;
        pos1 = point_pkg::P1_START;
        pos2 = point_pkg::P2_START;
        if (use1) begin
            pos1 = prev;
            pos1.x = prev.x + 10'(REACH); // Last pixel that still overlaps
        end
        if (use2) begin
            pos2 = prev;
            pos2.y = prev.y + 10'(REACH);
        end
        @(posedge clk);
        player1 <= pos1;
        player2 <= pos2;
        if (in_reach(prev, pos1))
            exp1 = exp1 + 1'b1;
        if (in_reach(prev, pos2))
            exp2 = exp2 + 1'b1;
        wait_valid(1'b0, PICKUP_LIMIT, "the pickup", ok);
        if (ok) begin
            check_score("score1", score1, exp1);
            check_score("score2", score2, exp2);
            @(posedge clk);
            player1 <= point_pkg::P1_START;
            player2 <= point_pkg::P2_START;
            wait_valid(1'b1, SPAWN_LIMIT, "the new point", ok);
            if (ok)
                check_spawn(prev, point);
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_coord("point", point, point_pkg::START_POINT);
        check_bit("point_valid", point_valid, 1'b1);
        check_score("score1", score1, 5'd0);
        check_score("score2", score2, 5'd0);
    endtask

    task automatic test_early_touch();
        point_pkg::coord_t held;
        held = point;
        repeat (50) @(posedge clk);
        player1 <= held; // Cooldown still running
        for (int i = 0; i < 100; i++) begin
            @(negedge clk);
            check_coord("point", point, held);
            check_score("score1", score1, 5'd0);
        end
    endtask

    task automatic test_first_pickup();
        do_pickup(1'b1, 1'b0);
        check_score("score1", score1, 5'd1);
        check_score("score2", score2, 5'd0);
    endtask

    task automatic test_respawn_series();
        for (int i = 0; i < 20; i++) begin
            if ($urandom % 2)
                do_pickup(1'b1, 1'b0);
            else
                do_pickup(1'b0, 1'b1);
        end
    endtask

    task automatic test_shared_pickup();
        do_pickup(1'b1, 1'b1);
    endtask

    task automatic test_near_miss_and_wrap();
        point_pkg::coord_t held;
        point_pkg::coord_t near1;
        point_pkg::coord_t near2;
        int pickups;
        held = point;
        near1 = held;
        near1.x = held.x + 10'd25; // One pixel past REACH
        near2 = held;
        near2.y = held.y + 10'd25;
        @(posedge clk);
        player1 <= near1;
        player2 <= near2;
        for (int i = 0; i < 2 * COOLDOWN; i++) begin
            @(negedge clk);
            check_score("score1", score1, exp1);
            check_score("score2", score2, exp2);
            check_bit("point_valid", point_valid, 1'b1);
        end
        pickups = 0;
        while ((pickups == 0) || ((exp1 != 5'd0) && (pickups < 32))) begin
            do_pickup(1'b1, 1'b0);
            pickups++;
        end
        check_score("score1", score1, 5'd0);
    endtask

    initial begin
        void'($urandom(56));
        errors = 0;
        exp1 = '0;
        exp2 = '0;
        rst <= 1'b1;
        player1 <= point_pkg::P1_START;
        player2 <= point_pkg::P2_START;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_early_touch();
        test_first_pickup();
        test_respawn_series();
        test_shared_pickup();
        test_near_miss_and_wrap();
        $display("Summary: %0d errors, score1 %0d, score2 %0d", errors, score1, score2);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: list.f
design/point_pkg.sv
design/terrain_map.sv
design/cooldown_timer.sv
design/score_keeper.sv
design/point_round_fsm.sv
design/point_spawner.sv
design/point_game_top.sv
sim/point_game_tb.sv
